// ==== include/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and storage sizes.
`define CPU_DATA_W 16
`define CPU_REG_N  16
`define CPU_MEM_N  16

// opcode values, held in bits 15..12 of the instruction.
`define CPU_OP_ADD 4'h0
`define CPU_OP_SUB 4'h1
`define CPU_OP_AND 4'h2
`define CPU_OP_OR  4'h3
`define CPU_OP_XOR 4'h4
`define CPU_OP_SHL 4'h5
`define CPU_OP_SHR 4'h6
`define CPU_OP_LDI 4'h7
`define CPU_OP_LD  4'h8
`define CPU_OP_ST  4'h9

`endif

// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    `include "cpu_consts.svh"

    typedef logic [`CPU_DATA_W-1:0]         word_t;
    typedef logic [$clog2(`CPU_REG_N)-1:0]  reg_addr_t;

    // opcode in 15..12, rd in 11..8, ra in 7..4, rb in 3..0.
    // LDI carries an 8-bit immediate in 7..0.
    typedef logic [15:0] instr_t;

    typedef enum logic [3:0] {
        op_add = `CPU_OP_ADD,
        op_sub = `CPU_OP_SUB,
        op_and = `CPU_OP_AND,
        op_or  = `CPU_OP_OR,
        op_xor = `CPU_OP_XOR,
        op_shl = `CPU_OP_SHL,
        op_shr = `CPU_OP_SHR,
        op_ldi = `CPU_OP_LDI,
        op_ld  = `CPU_OP_LD,
        op_st  = `CPU_OP_ST
    } opcode_e;

    typedef enum logic [2:0] {
        alu_pass_b,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_shl,
        alu_shr
    } alu_control_e;

    typedef struct packed {
        logic mem_rd;
        logic mem_wr;
    } memc_t;

    typedef struct packed {
        word_t a;
        word_t b;
    } alu_in_t;

    typedef struct packed {
        logic zero;
        logic carry;
    } status_t;

    typedef struct packed {
        logic         valid;
        alu_in_t      alu_in;
        alu_control_e alu_control;
        memc_t        memc;
        word_t        r1_data;
        reg_addr_t    ra;
        reg_addr_t    rb;
        reg_addr_t    rd;
        logic         reg_wr;
    } dec_t;

    typedef struct packed {
        logic      valid;
        memc_t     memc;
        word_t     alu_out;
        word_t     r1_data;
        reg_addr_t rd;
        logic      reg_wr;
    } ex_t;

endpackage

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module register_file (
    input  wire                clk,
    input  wire                rst,
    input  cpu_pkg::reg_addr_t rd_addr_a,
    input  cpu_pkg::reg_addr_t rd_addr_b,
    input  cpu_pkg::reg_addr_t rd_addr_c,
    input  wire                wr_en,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  cpu_pkg::word_t     wr_data,
    output cpu_pkg::word_t     rd_data_a,
    output cpu_pkg::word_t     rd_data_b,
    output cpu_pkg::word_t     rd_data_c
);

    cpu_pkg::word_t regs [`CPU_REG_N];

    // a read of the register being written this cycle sees the new value.
    function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_addr_t addr);
        if (wr_en && (wr_addr == addr)) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CPU_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
        rd_data_c = read_port(rd_addr_c);
    end

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 stall,
    input  wire                 instr_valid,
    input  cpu_pkg::instr_t     instr,
    input  cpu_pkg::word_t      rd_data_a,
    input  cpu_pkg::word_t      rd_data_b,
    input  cpu_pkg::word_t      rd_data_c,
    output cpu_pkg::reg_addr_t  rd_addr_a,
    output cpu_pkg::reg_addr_t  rd_addr_b,
    output cpu_pkg::reg_addr_t  rd_addr_c,
    output cpu_pkg::dec_t       dec
);

    cpu_pkg::opcode_e opcode;
    logic             is_mem;
    cpu_pkg::dec_t    dec_next;

    assign opcode = cpu_pkg::opcode_e'(instr[15:12]);
    assign is_mem = (opcode == cpu_pkg::op_ld) || (opcode == cpu_pkg::op_st);

    // loads and stores route ra onto operand b, so the address is a pass_b
    // and forwarding on b tracks ra for them.
    assign rd_addr_a = instr[7:4];
    assign rd_addr_b = is_mem ? instr[7:4] : instr[3:0];
    assign rd_addr_c = instr[11:8];

    always_comb begin
        dec_next             = '0;
        dec_next.valid       = instr_valid;
        dec_next.alu_in.a    = rd_data_a;
        dec_next.alu_in.b    = rd_data_b;
        dec_next.alu_control = cpu_pkg::alu_pass_b;
        dec_next.r1_data     = rd_data_c;
        dec_next.ra          = rd_addr_a;
        dec_next.rb          = rd_addr_b;
        dec_next.rd          = rd_addr_c;

        case (opcode)
            cpu_pkg::op_add: dec_next.alu_control = cpu_pkg::alu_add;
            cpu_pkg::op_sub: dec_next.alu_control = cpu_pkg::alu_sub;
            cpu_pkg::op_and: dec_next.alu_control = cpu_pkg::alu_and;
            cpu_pkg::op_or:  dec_next.alu_control = cpu_pkg::alu_or;
            cpu_pkg::op_xor: dec_next.alu_control = cpu_pkg::alu_xor;
            cpu_pkg::op_shl: dec_next.alu_control = cpu_pkg::alu_shl;
            cpu_pkg::op_shr: dec_next.alu_control = cpu_pkg::alu_shr;
            cpu_pkg::op_ldi: dec_next.alu_in.b = cpu_pkg::word_t'(instr[7:0]);
            cpu_pkg::op_ld:  dec_next.memc.mem_rd = instr_valid;
            cpu_pkg::op_st:  dec_next.memc.mem_wr = instr_valid;
            default: ;
        endcase

        // stores and undefined opcodes leave the register file alone.
        dec_next.reg_wr = instr_valid && (opcode <= cpu_pkg::op_ld);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec <= '0;
        end else if (!stall) begin
            dec <= dec_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_in_t      in,
    input  cpu_pkg::alu_control_e control,
    output cpu_pkg::word_t        out,
    output cpu_pkg::status_t      stat
);

    localparam int sh_w = $clog2($bits(cpu_pkg::word_t));

    logic [sh_w-1:0] shamt;
    cpu_pkg::word_t  res;
    logic            carry;

    assign shamt = in.b[sh_w-1:0];

    always_comb begin
        res   = in.b;
        carry = 1'b0;
        case (control)
            cpu_pkg::alu_add: {carry, res} = {1'b0, in.a} + {1'b0, in.b};
            // the top bit wraps to one exactly when a borrow is taken.
            cpu_pkg::alu_sub: {carry, res} = {1'b0, in.a} - {1'b0, in.b};
            cpu_pkg::alu_and: res = in.a & in.b;
            cpu_pkg::alu_or:  res = in.a | in.b;
            cpu_pkg::alu_xor: res = in.a ^ in.b;
            // the extra bit on each shift catches the last bit pushed out.
            cpu_pkg::alu_shl: {carry, res} = {1'b0, in.a} << shamt;
            cpu_pkg::alu_shr: {res, carry} = {in.a, 1'b0} >> shamt;
            default: res = in.b;
        endcase
    end

    assign out        = res;
    assign stat.zero  = (res == '0);
    assign stat.carry = carry;

endmodule

`default_nettype wire

// ==== logic/forwarding_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module forwarding_unit (
    input  cpu_pkg::dec_t      dec,
    input  cpu_pkg::reg_addr_t s3_rd,
    input  wire                s3_reg_wr,
    output logic               haz1,
    output logic               haz2,
    output logic               haz8
);

    logic is_ldi;

    // LDI is the only pass_b that touches no memory, and its b is an immediate.
    assign is_ldi = (dec.alu_control == cpu_pkg::alu_pass_b) &&
                    !dec.memc.mem_rd && !dec.memc.mem_wr;

    assign haz1 = s3_reg_wr && (dec.ra == s3_rd);
    assign haz2 = s3_reg_wr && (dec.rb == s3_rd) && !is_ldi;
    // the store source is the rd field.
    assign haz8 = s3_reg_wr && (dec.rd == s3_rd) && dec.memc.mem_wr;

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  wire               clk,
    input  wire               rst,
    input  wire               stall,
    input  cpu_pkg::dec_t     dec,
    input  wire               haz1,
    input  wire               haz2,
    input  wire               haz8,
    input  cpu_pkg::word_t    s3_data,
    output cpu_pkg::ex_t      ex,
    output cpu_pkg::status_t  flags
);

    cpu_pkg::alu_in_t alu_muxed;
    cpu_pkg::word_t   r1_data_muxed;
    cpu_pkg::word_t   alu_out;
    cpu_pkg::status_t alu_stat;
    cpu_pkg::status_t stat_q;

    // operand and store data selects between the decoded value and the
    // result being retired one stage ahead.
    assign alu_muxed.a   = haz1 ? s3_data : dec.alu_in.a;
    assign alu_muxed.b   = haz2 ? s3_data : dec.alu_in.b;
    assign r1_data_muxed = haz8 ? s3_data : dec.r1_data;

    alu main_alu (
        .in      (alu_muxed),
        .control (dec.alu_control),
        .out     (alu_out),
        .stat    (alu_stat)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex     <= '0;
            stat_q <= '0;
            flags  <= '0;
        end else if (!stall) begin
            ex.valid   <= dec.valid;
            ex.memc    <= dec.memc;
            ex.alu_out <= alu_out;
            ex.r1_data <= r1_data_muxed;
            ex.rd      <= dec.rd;
            ex.reg_wr  <= dec.reg_wr;
            // status rides along one more stage so flags match the write-back.
            stat_q     <= alu_stat;
            flags      <= stat_q;
        end
    end

endmodule

`default_nettype wire

// ==== logic/memory_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module memory_stage (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 stall,
    input  cpu_pkg::ex_t        ex,
    output logic                wr_en,
    output cpu_pkg::reg_addr_t  wr_addr,
    output cpu_pkg::word_t      wr_data,
    output cpu_pkg::word_t      s3_data,
    output cpu_pkg::reg_addr_t  s3_rd,
    output logic                s3_reg_wr
);

    localparam int mem_aw = $clog2(`CPU_MEM_N);

    cpu_pkg::word_t     mem [`CPU_MEM_N];
    logic [mem_aw-1:0]  mem_addr;
    logic               s3_reg_wr_q;

    assign mem_addr = ex.alu_out[mem_aw-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CPU_MEM_N; i++) begin
                mem[i] <= '0;
            end
        end else if (!stall && ex.valid && ex.memc.mem_wr) begin
            mem[mem_addr] <= ex.r1_data;
        end
    end

    // the result is written into the register file at the edge that latches
    // stage 3, so the same value feeds forwarding and the write-through read.
    assign wr_en   = ex.reg_wr & ~stall;
    assign wr_addr = ex.rd;
    assign wr_data = ex.memc.mem_rd ? mem[mem_addr] : ex.alu_out;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s3_reg_wr_q <= 1'b0;
        end else if (!stall) begin
            s3_reg_wr_q <= ex.reg_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s3_data <= wr_data;
            s3_rd   <= ex.rd;
        end
    end

    // the retire strobe drops while stalled, so each record shows once.
    assign s3_reg_wr = s3_reg_wr_q & ~stall;

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_core (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 stall,
    input  wire                 instr_valid,
    input  cpu_pkg::instr_t     instr,
    output logic                wb_en,
    output cpu_pkg::reg_addr_t  wb_addr,
    output cpu_pkg::word_t      wb_data,
    output cpu_pkg::status_t    flags
);

    cpu_pkg::reg_addr_t rd_addr_a;
    cpu_pkg::reg_addr_t rd_addr_b;
    cpu_pkg::reg_addr_t rd_addr_c;
    cpu_pkg::word_t     rd_data_a;
    cpu_pkg::word_t     rd_data_b;
    cpu_pkg::word_t     rd_data_c;
    cpu_pkg::dec_t      dec;
    cpu_pkg::ex_t       ex;
    logic               haz1;
    logic               haz2;
    logic               haz8;
    logic               wr_en;
    cpu_pkg::reg_addr_t wr_addr;
    cpu_pkg::word_t     wr_data;

    register_file u_register_file (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_addr_c (rd_addr_c),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .rd_data_c (rd_data_c)
    );

    decode_stage u_decode_stage (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .rd_data_c   (rd_data_c),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .rd_addr_c   (rd_addr_c),
        .dec         (dec)
    );

    // forwarding taps the result on its way into the register file.
    forwarding_unit u_forwarding_unit (
        .dec       (dec),
        .s3_rd     (wr_addr),
        .s3_reg_wr (wr_en),
        .haz1      (haz1),
        .haz2      (haz2),
        .haz8      (haz8)
    );

    execute_stage u_execute_stage (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .dec     (dec),
        .haz1    (haz1),
        .haz2    (haz2),
        .haz8    (haz8),
        .s3_data (wr_data),
        .ex      (ex),
        .flags   (flags)
    );

    memory_stage u_memory_stage (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .ex        (ex),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .s3_data   (wb_data),
        .s3_rd     (wb_addr),
        .s3_reg_wr (wb_en)
    );

endmodule

`default_nettype wire

// ==== testbench/cpu_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_core_tb;

    localparam int exp_depth  = 1024;
    localparam int wait_limit = 200;

    logic               clk;
    logic               rst;
    logic               stall;
    logic               instr_valid;
    cpu_pkg::instr_t    instr;
    logic               wb_en;
    cpu_pkg::reg_addr_t wb_addr;
    cpu_pkg::word_t     wb_data;
    cpu_pkg::status_t   flags;

    // serial reference state, updated in program order at acceptance.
    cpu_pkg::word_t     model_regs [`CPU_REG_N];
    cpu_pkg::word_t     model_mem [`CPU_MEM_N];

    // expected write-backs, filled by the stimulus and consumed by the checker.
    cpu_pkg::reg_addr_t exp_addr [exp_depth];
    cpu_pkg::word_t     exp_data [exp_depth];
    cpu_pkg::status_t   exp_flags [exp_depth];
    int                 exp_adv [exp_depth];
    int                 exp_wr;
    int                 exp_rd;

    // unstalled rising edges since reset, which place each write-back in time.
    int                 adv_count;

    int                 check_count;
    int                 error_count;
    int                 timeout_count;
    logic               started;
    int unsigned        stall_pct;
    int unsigned        gap_pct;

    cpu_core i_dut (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .flags       (flags)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic cpu_pkg::instr_t encode(input logic [3:0] op, input int rd,
                                               input int ra, input int rb);
        return {op, 4'(rd), 4'(ra), 4'(rb)};
    endfunction

    function automatic cpu_pkg::instr_t encode_ldi(input int rd, input int imm);
        return {`CPU_OP_LDI, 4'(rd), 8'(imm)};
    endfunction

    function automatic logic chance(input int unsigned pct);
        return ($urandom % 100) < pct;
    endfunction

    task automatic apply_model(input cpu_pkg::instr_t word);
        logic [3:0]       op;
        int               rd;
        int               sh;
        cpu_pkg::word_t   a;
        cpu_pkg::word_t   b;
        cpu_pkg::word_t   res;
        cpu_pkg::status_t st;
        op       = word[15:12];
        rd       = int'(word[11:8]);
        a        = model_regs[word[7:4]];
        b        = model_regs[word[3:0]];
        sh       = int'(b[3:0]);
        res      = '0;
        st.carry = 1'b0;
        case (op)
            `CPU_OP_ADD: begin
                res      = a + b;
                st.carry = (32'(a) + 32'(b)) > 32'hffff;
            end
            `CPU_OP_SUB: begin
                res      = a - b;
                st.carry = a < b;
            end
            `CPU_OP_AND: res = a & b;
            `CPU_OP_OR:  res = a | b;
            `CPU_OP_XOR: res = a ^ b;
            `CPU_OP_SHL: begin
                res      = a << sh;
                st.carry = (sh == 0) ? 1'b0 : a[16 - sh];
            end
            `CPU_OP_SHR: begin
                res      = a >> sh;
                st.carry = (sh == 0) ? 1'b0 : a[sh - 1];
            end
            `CPU_OP_LDI: res = {8'h00, word[7:0]};
            default: res = a;
        endcase
        // the status belongs to the ALU result, which is the address for memory ops.
        st.zero = (res == '0);
        if (op == `CPU_OP_LD) begin
            res = model_mem[a[3:0]];
        end
        if (op == `CPU_OP_ST) begin
            model_mem[a[3:0]] = model_regs[rd];
        end else if (exp_wr < exp_depth) begin
            exp_addr[exp_wr]  = 4'(rd);
            exp_data[exp_wr]  = res;
            exp_flags[exp_wr] = st;
            exp_adv[exp_wr]   = adv_count;
            exp_wr++;
            model_regs[rd] = res;
        end
    endtask

    // presents one instruction, with random stall and gap cycles, until it is taken.
    task automatic issue(input cpu_pkg::instr_t word);
        int   tries;
        logic taken;
        tries = 0;
        taken = 1'b0;
        while (!taken && tries < wait_limit) begin
            stall = chance(stall_pct);
            if (chance(gap_pct)) begin
                instr_valid = 1'b0;
                instr       = cpu_pkg::instr_t'($urandom);
            end else begin
                instr_valid = 1'b1;
                instr       = word;
            end
            taken = instr_valid && !stall;
            if (taken) begin
                apply_model(word);
                started = 1'b1;
            end
            @(posedge clk);
            #2;
            tries++;
        end
        if (!taken) begin
            $display("timeout: instruction %h was never accepted", word);
            timeout_count++;
        end
    endtask

    task automatic drain_expected();
        int cycles;
        stall       = 1'b0;
        instr_valid = 1'b0;
        cycles      = 0;
        while (exp_rd < exp_wr && cycles < wait_limit) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (exp_rd < exp_wr) begin
            $display("timeout: %0d write-backs never appeared", exp_wr - exp_rd);
            timeout_count++;
        end
    endtask

    task automatic run_directed();
        issue(encode_ldi(1, 'h3c));
        issue(encode_ldi(2, 'h05));
        issue(encode_ldi(3, 'hff));
        issue(encode_ldi(0, 'h00));
        issue(encode(`CPU_OP_ADD, 4, 1, 2));
        issue(encode(`CPU_OP_SUB, 5, 2, 1));
        issue(encode(`CPU_OP_SUB, 6, 1, 1));
        issue(encode(`CPU_OP_AND, 7, 1, 3));
        issue(encode(`CPU_OP_OR, 8, 1, 2));
        issue(encode(`CPU_OP_XOR, 9, 3, 1));
        issue(encode(`CPU_OP_SHL, 10, 3, 2));
        issue(encode(`CPU_OP_SHR, 11, 3, 2));
        issue(encode(`CPU_OP_SHL, 12, 3, 0));
        // 0xff shifted to the top byte, then doubled for an add carry.
        issue(encode_ldi(13, 'h08));
        issue(encode(`CPU_OP_SHL, 14, 3, 13));
        issue(encode(`CPU_OP_ADD, 15, 14, 14));
        // distance-one and distance-two dependencies on ra and rb.
        issue(encode_ldi(1, 'h07));
        issue(encode(`CPU_OP_ADD, 2, 1, 1));
        issue(encode(`CPU_OP_ADD, 3, 2, 1));
        issue(encode(`CPU_OP_ADD, 4, 1, 3));
        // store data written just before the store, then read back.
        issue(encode_ldi(5, 'h9a));
        issue(encode(`CPU_OP_ST, 5, 1, 0));
        issue(encode(`CPU_OP_LD, 6, 1, 0));
        issue(encode_ldi(7, 'h44));
        issue(encode_ldi(8, 'h03));
        issue(encode(`CPU_OP_ST, 7, 8, 0));
        issue(encode(`CPU_OP_LD, 9, 8, 0));
        issue(encode(`CPU_OP_ADD, 10, 9, 9));
    endtask

    task automatic run_random(input int count);
        cpu_pkg::instr_t word;
        for (int i = 0; i < count; i++) begin
            word        = cpu_pkg::instr_t'($urandom);
            word[15:12] = 4'($urandom % 10);
            issue(word);
        end
    endtask

    task automatic read_final_state();
        for (int m = 0; m < `CPU_MEM_N; m++) begin
            issue(encode_ldi(0, m));
            issue(encode(`CPU_OP_LD, 1, 0, 0));
        end
        for (int r = 0; r < `CPU_REG_N; r++) begin
            issue(encode(`CPU_OP_OR, r, r, r));
        end
    endtask

    always @(posedge clk) begin
        if (!rst && !stall) begin
            adv_count++;
        end
    end

    // outputs are sampled on the falling edge, away from input changes.
    // a write-back is due three unstalled edges after the model saw it.
    always @(negedge clk) begin
        if (rst || !started) begin
            assert (!wb_en) else begin
                $display("FAIL t=%0t wb_en got %b expected 0", $time, wb_en);
                error_count++;
            end
        end
        assert (!(wb_en && stall)) else begin
            $display("FAIL t=%0t wb_en got %b expected 0 while stalled", $time, wb_en);
            error_count++;
        end
        if (wb_en && !rst && started) begin
            if (exp_rd >= exp_wr) begin
                $display("t=%0t a write-back appeared with none outstanding", $time);
                error_count++;
            end else begin
                check_count++;
                assert (adv_count == exp_adv[exp_rd] + 3) else begin
                    $display("FAIL t=%0t wb_en got 1 expected 0 in this cycle", $time);
                    error_count++;
                end
                assert (wb_addr == exp_addr[exp_rd]) else begin
                    $display("FAIL t=%0t wb_addr got %h expected %h",
                             $time, wb_addr, exp_addr[exp_rd]);
                    error_count++;
                end
                assert (wb_data == exp_data[exp_rd]) else begin
                    $display("FAIL t=%0t wb_data got %h expected %h",
                             $time, wb_data, exp_data[exp_rd]);
                    error_count++;
                end
                assert (flags == exp_flags[exp_rd]) else begin
                    $display("FAIL t=%0t flags got %b expected %b",
                             $time, flags, exp_flags[exp_rd]);
                    error_count++;
                end
                exp_rd++;
            end
        end else if (!rst && !stall && exp_rd < exp_wr) begin
            assert (adv_count != exp_adv[exp_rd] + 3) else begin
                $display("FAIL t=%0t wb_en got %b expected 1", $time, wb_en);
                error_count++;
            end
        end
    end

    initial begin
        #400000;
        $display("timeout: the simulation ran past its time limit");
        timeout_count++;
        $display("checks=%0d errors=%0d timeouts=%0d", check_count, error_count,
                 timeout_count);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(88));
        rst           = 1'b1;
        stall         = 1'b0;
        instr_valid   = 1'b0;
        instr         = '0;
        started       = 1'b0;
        exp_wr        = 0;
        exp_rd        = 0;
        adv_count     = 0;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        stall_pct     = 0;
        gap_pct       = 0;
        for (int i = 0; i < `CPU_REG_N; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `CPU_MEM_N; i++) begin
            model_mem[i] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (4) @(posedge clk);
        #2;

        run_directed();
        drain_expected();
        // the same directed stream again under stalls and gaps.
        stall_pct = 30;
        gap_pct   = 20;
        run_directed();
        run_random(300);
        read_final_state();
        drain_expected();
        repeat (6) @(posedge clk);
        #2;

        $display("checks=%0d errors=%0d timeouts=%0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
logic/cpu_pkg.sv
logic/register_file.sv
logic/decode_stage.sv
logic/alu.sv
logic/forwarding_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_core.sv
testbench/cpu_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f all.f --top-module cpu_core_tb -Mdir obj_dir -o cpu_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/cpu_core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$log"; then
    exit 1
fi
exit 0
